// ==== verification/imager_stim.txt ====
// Lookup pairs: count, then table address and value, two pairs per line (hex)
// Frames: count, then per frame row count, column count and the pixels row by row
008
010 3ff  020 000
030 155  040 2aa
055 001  0a0 123
123 0a0  3ff 010
004
002 004
001 002 003 3ff
200 100 080 040
003 005
010 020 030 040 055
0a0 123 3ff 010 020
030 040 055 0a0 123
004 008
011 022 033 044 055 066 077 088
099 0aa 0bb 0cc 0dd 0ee 0ff 100
101 102 103 104 105 106 107 108
2f0 2f1 2f2 2f3 2f4 2f5 2f6 2f7
002 003
3a0 3a1 3a2
3b0 3b1 3b2

// ==== vlog.f ====
+incdir+verification
design/imager_pkg.sv
design/frame_rx.sv
design/pixel_map.sv
design/stream_capture.sv
design/imager_regs.sv
design/imager_top.sv
verification/imager_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module imager_tb -Mdir obj_dir -o imager_sim -f vlog.f

./obj_dir/imager_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== verification/imager_tb_checks.svh ====
`ifndef IMAGER_TB_CHECKS_SVH
`define IMAGER_TB_CHECKS_SVH

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_word(input string name, input logic [REG_DATA_W-1:0] got,
                          input logic [REG_DATA_W-1:0] exp);
   if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   end
endtask

task automatic check_tag(input string name, input stream_tag_t got, input stream_tag_t exp);
   if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s tag got 0x%h expected 0x%h", name, got, exp));
   end
endtask

task automatic check_dims(input logic [DIM_W-1:0] got_rows, input logic [DIM_W-1:0] got_cols,
                          input logic [DIM_W-1:0] exp_rows, input logic [DIM_W-1:0] exp_cols);
   if (got_rows !== exp_rows) begin
      fail_run($sformatf("CHECK FAILED num_rows got 0x%h expected 0x%h", got_rows, exp_rows));
   end
   if (got_cols !== exp_cols) begin
      fail_run($sformatf("CHECK FAILED num_cols got 0x%h expected 0x%h", got_cols, exp_cols));
   end
endtask

// ----------------------------------------------------------------------
// Expected words
// ----------------------------------------------------------------------
function automatic logic [REG_DATA_W-1:0] capture_word(input logic valid, input logic ovf,
                                                      input stream_tag_t tag,
                                                      input logic [DATA_W-1:0] data);
   logic [REG_DATA_W-1:0] w;
   w                = '0;
   w[CAP_VALID_BIT] = valid;
   w[CAP_OVF_BIT]   = ovf;
   if (valid) begin   // Fields zero on an empty buffer
      w[CAP_TAG_LSB +: 2]       = tag;
      w[CAP_DATA_LSB +: DATA_W] = data;
   end
   return w;
endfunction

// One frame of stream words, raw or through the table
task automatic build_expected(input int f, input logic mapped);
   logic [PIXEL_W-1:0] pix;
   exp_tag_q.delete();
   exp_data_q.delete();
   exp_tag_q.push_back(TAG_FRAME_START);
   exp_data_q.push_back(DATA_W'(0));
   for (int r = 0; r < frame_rows[f]; r++) begin
      for (int c = 0; c < frame_cols[f]; c++) begin
         pix = stim_mem[frame_base[f] + r * frame_cols[f] + c][PIXEL_W-1:0];
         if (mapped) pix = lut_model[pix];
         exp_tag_q.push_back(TAG_PIXEL);
         exp_data_q.push_back(DATA_W'(pix));
      end
      exp_tag_q.push_back(TAG_ROW_END);
      exp_data_q.push_back(DATA_W'(frame_cols[f]));   // Column count
   end
   exp_tag_q.push_back(TAG_FRAME_END);
   exp_data_q.push_back(DATA_W'(frame_rows[f]));
endtask

`endif

// ==== verification/imager_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module imager_tb import imager_pkg::*; ();

   localparam int DEPTH    = 32;   // Capture depth that frame 2 overflows
   localparam int ACK_WAIT = 8;
   localparam int N_FRAMES = 4;

   logic                  clk = 1'b0;
   logic                  resetb;
   logic                  fv;
   logic                  lv;
   logic [PIXEL_W-1:0]    pix_data;
   logic [REG_ADDR_W-1:0] reg_addr;
   logic                  reg_write;
   logic                  reg_read;
   logic [REG_DATA_W-1:0] reg_wdata;
   logic [REG_DATA_W-1:0] reg_rdata;
   logic                  reg_ack;

   logic [15:0]           stim_mem [256];
   logic [PIXEL_W-1:0]    lut_model [2**PIXEL_W];
   int                    frame_rows [N_FRAMES];
   int                    frame_cols [N_FRAMES];
   int                    frame_base [N_FRAMES];   // Index of first pixel
   stream_tag_t           exp_tag_q [$];
   logic [DATA_W-1:0]     exp_data_q [$];
   logic [7:0]            lfsr = 8'd47;
   int                    cycle_cnt = 0;
   int                    timeout_limit = 100000;

   imager_top #(.PIXEL_W(PIXEL_W), .CAP_DEPTH(DEPTH)) u_imager_top (
      .clk(clk), .resetb(resetb), .fv(fv), .lv(lv), .pix_data(pix_data),
      .reg_addr(reg_addr), .reg_write(reg_write), .reg_read(reg_read),
      .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .reg_ack(reg_ack)
   );

   always #2 clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   `include "imager_tb_checks.svh"

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_limit) fail_run("Timeout, the test sequence did not finish");
   end

   // ----------------------------------------------------------------------
   // Bus and sensor drivers 1 ns after the edge
   // ----------------------------------------------------------------------
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic finish_access(output logic [REG_DATA_W-1:0] rdata);
      int waited;
      waited = 0;
      step();
      reg_write = 1'b0;
      reg_read  = 1'b0;
      while (reg_ack !== 1'b1 && waited < ACK_WAIT) begin
         step();
         waited++;
      end
      if (reg_ack !== 1'b1) fail_run("No ack from the register bus");
      rdata = reg_rdata;
      step();
      if (reg_ack !== 1'b0) fail_run("Register ack held for more than one cycle");
   endtask

   task automatic write_reg(input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] wdata);
      logic [REG_DATA_W-1:0] ignored;
      reg_addr  = addr;
      reg_wdata = wdata;
      reg_write = 1'b1;
      finish_access(ignored);
   endtask

   task automatic read_reg(input logic [REG_ADDR_W-1:0] addr,
                           output logic [REG_DATA_W-1:0] rdata);
      reg_addr = addr;
      reg_read = 1'b1;
      finish_access(rdata);
   endtask

   function automatic logic [7:0] galois_step(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   // Row blanking of 1 to 4 cycles from two LFSR bits
   function automatic int next_gap();
      int gap;
      gap = 1;
      for (int b = 0; b < 2; b++) begin
         lfsr = galois_step(lfsr);
         gap += int'(lfsr[0]) << b;
      end
      return gap;
   endfunction

   task automatic drive_frame(input int f);
      int gap;
      fv = 1'b1;   // One idle cycle before the first row
      step();
      for (int r = 0; r < frame_rows[f]; r++) begin
         for (int c = 0; c < frame_cols[f]; c++) begin
            lv       = 1'b1;
            pix_data = stim_mem[frame_base[f] + r * frame_cols[f] + c][PIXEL_W-1:0];
            step();
         end
         lv  = 1'b0;
         gap = next_gap();
         repeat (gap) step();
      end
      fv = 1'b0;
      repeat (4) step();   // Receiver and map stage latency
   endtask

   task automatic run_frame(input int f, input logic [1:0] ctrl);
      write_reg(REG_CTRL, {30'd0, ctrl});
      write_reg(REG_ARM, '0);
      drive_frame(f);
   endtask

   task automatic check_capture(input logic [REG_ADDR_W-1:0] addr, input string name,
                                input int f, input logic mapped);
      logic [REG_DATA_W-1:0] word;
      logic                  ovf;
      int                    n;
      build_expected(f, mapped);
      ovf = exp_tag_q.size() > DEPTH;
      n   = ovf ? DEPTH : exp_tag_q.size();
      for (int i = 0; i < n; i++) begin
         read_reg(addr, word);
         check_tag(name, stream_tag_t'(word[CAP_TAG_LSB +: 2]), exp_tag_q[i]);
         check_word(name, word, capture_word(1'b1, ovf, exp_tag_q[i], exp_data_q[i]));
      end
      read_reg(addr, word);   // Drained
      check_word(name, word, capture_word(1'b0, ovf, TAG_FRAME_START, DATA_W'(0)));
   endtask

   task automatic check_frame_dims(input int f);
      logic [REG_DATA_W-1:0] word;
      read_reg(REG_DIMS, word);
      check_dims(word[DIMS_ROWS_LSB +: DIM_W], word[DIMS_COLS_LSB +: DIM_W],
                 DIM_W'(frame_rows[f]), DIM_W'(frame_cols[f]));
   endtask

   task automatic load_table(input int n_pairs);
      logic [REG_DATA_W-1:0] word;
      logic [PIXEL_W-1:0]    addr;
      logic [PIXEL_W-1:0]    value;
      for (int i = 0; i < n_pairs; i++) begin
         addr             = stim_mem[1 + 2 * i][PIXEL_W-1:0];
         value            = stim_mem[2 + 2 * i][PIXEL_W-1:0];
         lut_model[addr]  = value;
         word             = '0;
         word[LUT_ADDR_LSB +: PIXEL_W] = addr;
         word[LUT_DATA_LSB +: PIXEL_W] = value;
         write_reg(REG_LUT, word);
      end
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      logic [REG_DATA_W-1:0] word;
      int                    ptr;
      int                    n_pairs;
      int                    budget;
      resetb    = 1'b0;
      fv        = 1'b0;
      lv        = 1'b0;
      pix_data  = '0;
      reg_addr  = '0;
      reg_write = 1'b0;
      reg_read  = 1'b0;
      reg_wdata = '0;
      foreach (stim_mem[i]) stim_mem[i] = '1;
      $readmemh("verification/imager_stim.txt", stim_mem);
      n_pairs = int'(stim_mem[0]);
      ptr     = 1 + 2 * n_pairs;
      if (ptr > 200 || int'(stim_mem[ptr]) != N_FRAMES) begin
         fail_run("Stimulus file missing or not in the expected format");
      end
      ptr++;
      budget = 0;
      for (int f = 0; f < N_FRAMES; f++) begin
         frame_rows[f] = int'(stim_mem[ptr]);
         frame_cols[f] = int'(stim_mem[ptr + 1]);
         frame_base[f] = ptr + 2;
         ptr    += 2 + frame_rows[f] * frame_cols[f];
         budget += frame_rows[f] * (frame_cols[f] + 6);
      end
      timeout_limit = 2 * budget + 2000;

      repeat (10) step();
      resetb = 1'b1;

      write_reg(REG_CTRL, 32'h3);
      read_reg(REG_CTRL, word);
      check_word("reg_rdata ctrl", word, 32'h3);
      write_reg(REG_CTRL, 32'h1);
      read_reg(REG_CTRL, word);
      check_word("reg_rdata ctrl", word, 32'h1);
      load_table(n_pairs);

      run_frame(0, 2'b01);   // Map off
      check_capture(REG_CAP_IN, "cap_in head_word", 0, 1'b0);
      check_capture(REG_CAP_OUT, "cap_out head_word", 0, 1'b0);
      check_frame_dims(0);

      run_frame(1, 2'b11);   // Map on
      check_capture(REG_CAP_IN, "cap_in head_word", 1, 1'b0);
      check_capture(REG_CAP_OUT, "cap_out head_word", 1, 1'b1);
      check_frame_dims(1);

      run_frame(2, 2'b01);   // Longer than the FIFO
      check_capture(REG_CAP_IN, "cap_in head_word", 2, 1'b0);
      check_capture(REG_CAP_OUT, "cap_out head_word", 2, 1'b0);
      check_frame_dims(2);

      run_frame(3, 2'b00);   // Receiver off so nothing is recorded
      read_reg(REG_CAP_IN, word);
      check_word("cap_in head_word", word, capture_word(1'b0, 1'b0, TAG_FRAME_START, '0));
      read_reg(REG_CAP_OUT, word);
      check_word("cap_out head_word", word, capture_word(1'b0, 1'b0, TAG_FRAME_START, '0));
      check_frame_dims(2);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/imager_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module imager_top import imager_pkg::*; #(
   parameter int PIXEL_W   = imager_pkg::PIXEL_W,
   parameter int CAP_DEPTH = imager_pkg::CAP_DEPTH
) (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic                  fv,
   input  logic                  lv,
   input  logic [PIXEL_W-1:0]    pix_data,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic                  reg_write,
   input  logic                  reg_read,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   output logic [REG_DATA_W-1:0] reg_rdata,
   output logic                  reg_ack
);

   // Receiver stream
   logic                  rx_dv;
   stream_tag_t           rx_tag;
   logic [DATA_W-1:0]     rx_data;
   // Map stream
   logic                  map_dv;
   stream_tag_t           map_tag;
   logic [DATA_W-1:0]     map_data;

   logic [DIM_W-1:0]      num_rows;
   logic [DIM_W-1:0]      num_cols;
   logic                  enable;
   logic                  map_on;
   logic                  arm;
   logic                  lut_we;
   logic [PIXEL_W-1:0]    lut_addr;
   logic [PIXEL_W-1:0]    lut_data;
   logic                  pop_in;
   logic                  pop_out;
   logic [REG_DATA_W-1:0] head_in;
   logic [REG_DATA_W-1:0] head_out;

   frame_rx #(.PIXEL_W(PIXEL_W)) u_frame_rx (
      .clk(clk), .resetb(resetb), .enable(enable),
      .fv(fv), .lv(lv), .pix_data(pix_data),
      .dv(rx_dv), .tag(rx_tag), .data(rx_data),
      .num_rows(num_rows), .num_cols(num_cols)
   );

   pixel_map #(.PIXEL_W(PIXEL_W)) u_pixel_map (
      .clk(clk), .resetb(resetb), .map_on(map_on),
      .lut_we(lut_we), .lut_addr(lut_addr), .lut_data(lut_data),
      .dvi(rx_dv), .tagi(rx_tag), .datai(rx_data),
      .dvo(map_dv), .tago(map_tag), .datao(map_data)
   );

   // Taps before and after the map stage
   stream_capture #(.CAP_DEPTH(CAP_DEPTH)) u_cap_in (
      .clk(clk), .resetb(resetb), .arm(arm),
      .dv(rx_dv), .tag(rx_tag), .data(rx_data),
      .pop(pop_in), .head_word(head_in)
   );

   stream_capture #(.CAP_DEPTH(CAP_DEPTH)) u_cap_out (
      .clk(clk), .resetb(resetb), .arm(arm),
      .dv(map_dv), .tag(map_tag), .data(map_data),
      .pop(pop_out), .head_word(head_out)
   );

   imager_regs #(.PIXEL_W(PIXEL_W)) u_imager_regs (
      .clk(clk), .resetb(resetb),
      .reg_addr(reg_addr), .reg_write(reg_write), .reg_read(reg_read),
      .reg_wdata(reg_wdata), .num_rows(num_rows), .num_cols(num_cols),
      .head_in(head_in), .head_out(head_out),
      .reg_rdata(reg_rdata), .reg_ack(reg_ack),
      .enable(enable), .map_on(map_on), .arm(arm),
      .lut_we(lut_we), .lut_addr(lut_addr), .lut_data(lut_data),
      .pop_in(pop_in), .pop_out(pop_out)
   );

endmodule

`default_nettype wire

// ==== design/imager_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module imager_regs import imager_pkg::*; #(
   parameter int PIXEL_W = imager_pkg::PIXEL_W
) (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic                  reg_write,
   input  logic                  reg_read,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   input  logic [DIM_W-1:0]      num_rows,
   input  logic [DIM_W-1:0]      num_cols,
   input  logic [REG_DATA_W-1:0] head_in,
   input  logic [REG_DATA_W-1:0] head_out,
   output logic [REG_DATA_W-1:0] reg_rdata,
   output logic                  reg_ack,
   output logic                  enable,
   output logic                  map_on,
   output logic                  arm,
   output logic                  lut_we,
   output logic [PIXEL_W-1:0]    lut_addr,
   output logic [PIXEL_W-1:0]    lut_data,
   output logic                  pop_in,
   output logic                  pop_out
);

   logic                  wr_ctrl;
   logic                  wr_arm;
   logic                  wr_lut;
   logic [REG_DATA_W-1:0] rd_mux;

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------
   assign wr_ctrl = reg_write && (reg_addr == REG_CTRL);
   assign wr_arm  = reg_write && (reg_addr == REG_ARM);
   assign wr_lut  = reg_write && (reg_addr == REG_LUT);

   // Pop in the request cycle, head is sampled on the same edge
   assign pop_in  = reg_read && (reg_addr == REG_CAP_IN);
   assign pop_out = reg_read && (reg_addr == REG_CAP_OUT);

   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         REG_CTRL: begin
            rd_mux[CTRL_ENABLE_BIT] = enable;
            rd_mux[CTRL_MAP_ON_BIT] = map_on;
         end
         REG_DIMS: begin
            rd_mux[DIMS_ROWS_LSB +: DIM_W] = num_rows;
            rd_mux[DIMS_COLS_LSB +: DIM_W] = num_cols;
         end
         REG_CAP_IN:  rd_mux = head_in;
         REG_CAP_OUT: rd_mux = head_out;
         default:     rd_mux = '0;   // Write-only and unmapped
      endcase
   end

   // ----------------------------------------------------------------------
   // Control state and pulses
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetb) begin
         reg_ack <= 1'b0;
         enable  <= 1'b0;
         map_on  <= 1'b0;
         arm     <= 1'b0;
         lut_we  <= 1'b0;
      end else begin
         reg_ack <= reg_write || reg_read;   // Every access, one cycle later
         arm     <= wr_arm;
         lut_we  <= wr_lut;
         if (wr_ctrl) begin
            enable <= reg_wdata[CTRL_ENABLE_BIT];
            map_on <= reg_wdata[CTRL_MAP_ON_BIT];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reg_read) begin
         reg_rdata <= rd_mux;
      end
      if (wr_lut) begin
         lut_addr <= reg_wdata[LUT_ADDR_LSB +: PIXEL_W];
         lut_data <= reg_wdata[LUT_DATA_LSB +: PIXEL_W];
      end
   end

endmodule

`default_nettype wire

// ==== design/stream_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_capture import imager_pkg::*; #(
   parameter int CAP_DEPTH = imager_pkg::CAP_DEPTH
) (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic                  arm,
   input  logic                  dv,
   input  stream_tag_t           tag,
   input  logic [DATA_W-1:0]     data,
   input  logic                  pop,
   output logic [REG_DATA_W-1:0] head_word
);

   localparam int AW    = (CAP_DEPTH > 1) ? $clog2(CAP_DEPTH) : 1;
   localparam int CW    = $clog2(CAP_DEPTH + 1);
   localparam int TAG_W = $bits(stream_tag_t);

   typedef enum logic [1:0] {CAP_IDLE, CAP_WAIT, CAP_REC} cap_state_t;

   cap_state_t              state;
   logic [TAG_W+DATA_W-1:0] mem [CAP_DEPTH];   // Tag above data
   logic [TAG_W+DATA_W-1:0] head;
   logic [AW-1:0]           wr_ptr;
   logic [AW-1:0]           rd_ptr;
   logic [CW-1:0]           count;
   logic                    ovf;
   logic                    take;
   logic                    full;
   logic                    empty;
   logic                    push;
   logic                    do_pop;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(CAP_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // Word belongs to the frame being captured
   assign take   = dv && ((state == CAP_REC) ||
                          (state == CAP_WAIT && tag == TAG_FRAME_START));
   assign full   = (count == CW'(CAP_DEPTH));
   assign empty  = (count == '0);
   assign push   = take && !full;
   assign do_pop = pop && !empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {tag, data};
      end
   end

   // ----------------------------------------------------------------------
   // Capture control and FIFO pointers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetb) begin
         state  <= CAP_IDLE;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         ovf    <= 1'b0;
      end else if (arm) begin
         state  <= CAP_WAIT;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         ovf    <= 1'b0;
      end else begin
         if (take) begin
            if (state == CAP_WAIT) begin
               state <= CAP_REC;
            end else if (tag == TAG_FRAME_END) begin
               state <= CAP_IDLE;   // One frame only
            end
            if (full) begin
               ovf <= 1'b1;         // Word dropped
            end
         end
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop) rd_ptr <= next_ptr(rd_ptr);
         if (push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign head = mem[rd_ptr];

   // Head in capture word layout
   always_comb begin
      head_word                = '0;
      head_word[CAP_VALID_BIT] = !empty;
      head_word[CAP_OVF_BIT]   = ovf;
      if (!empty) begin
         head_word[CAP_TAG_LSB +: TAG_W]   = head[DATA_W +: TAG_W];
         head_word[CAP_DATA_LSB +: DATA_W] = head[DATA_W-1:0];
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (!resetb)
      count <= CW'(CAP_DEPTH))
      else $error("stream_capture: count above depth");

endmodule

`default_nettype wire

// ==== design/pixel_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_map import imager_pkg::*; #(
   parameter int PIXEL_W = imager_pkg::PIXEL_W
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               map_on,
   input  logic               lut_we,
   input  logic [PIXEL_W-1:0] lut_addr,
   input  logic [PIXEL_W-1:0] lut_data,
   input  logic               dvi,
   input  stream_tag_t        tagi,
   input  logic [DATA_W-1:0]  datai,
   output logic               dvo,
   output stream_tag_t        tago,
   output logic [DATA_W-1:0]  datao
);

   localparam int LUT_N = 2**PIXEL_W;

   logic [PIXEL_W-1:0] lut [LUT_N];
   logic [PIXEL_W-1:0] lut_q;     // Table entry for the word in flight
   logic [DATA_W-1:0]  raw_q;
   logic               map_q;     // Take the table entry this cycle

   // ----------------------------------------------------------------------
   // Table, written from the register bus
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (lut_we) begin
         lut[lut_addr] <= lut_data;
      end
   end

   // ----------------------------------------------------------------------
   // One pipeline stage
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      lut_q <= lut[datai[PIXEL_W-1:0]];
      raw_q <= datai;
      tago  <= tagi;
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         dvo   <= 1'b0;
         map_q <= 1'b0;
      end else begin
         dvo   <= dvi;
         map_q <= map_on && dvi && (tagi == TAG_PIXEL);
      end
   end

   // Raw or mapped select
   assign datao = map_q ? {{(DATA_W-PIXEL_W){1'b0}}, lut_q} : raw_q;

   a_tag_known: assert property (@(posedge clk) disable iff (!resetb)
      dvo |-> !$isunknown(tago))
      else $error("pixel_map: unknown tag on a valid word");

endmodule

`default_nettype wire

// ==== design/frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_rx import imager_pkg::*; #(
   parameter int PIXEL_W = imager_pkg::PIXEL_W
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               enable,
   input  logic               fv,
   input  logic               lv,
   input  logic [PIXEL_W-1:0] pix_data,
   output logic               dv,
   output stream_tag_t        tag,
   output logic [DATA_W-1:0]  data,
   output logic [DIM_W-1:0]   num_rows,
   output logic [DIM_W-1:0]   num_cols
);

   logic             fv_d;
   logic             lv_d;
   logic             active;     // Frame accepted at its fv rise
   logic             fv_rise;
   logic             fv_fall;
   logic             lv_fall;
   logic [DIM_W-1:0] col_cnt;
   logic [DIM_W-1:0] row_cnt;
   logic [DIM_W-1:0] last_cols;

   assign fv_rise = fv & ~fv_d;
   assign fv_fall = ~fv & fv_d;
   assign lv_fall = ~lv & lv_d;

   // ----------------------------------------------------------------------
   // Edge tracking, counters and word valid
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetb) begin
         fv_d      <= 1'b0;
         lv_d      <= 1'b0;
         active    <= 1'b0;
         dv        <= 1'b0;
         col_cnt   <= '0;
         row_cnt   <= '0;
         last_cols <= '0;
         num_rows  <= '0;
         num_cols  <= '0;
      end else begin
         fv_d <= fv;
         lv_d <= lv;
         dv   <= 1'b0;
         if (fv_rise) begin
            active  <= enable;   // Disabled frames are skipped whole
            dv      <= enable;
            row_cnt <= '0;
            col_cnt <= '0;
         end else if (active) begin
            if (lv) begin
               dv      <= 1'b1;
               col_cnt <= col_cnt + 1'b1;
            end else if (lv_fall) begin
               dv        <= 1'b1;
               row_cnt   <= row_cnt + 1'b1;
               last_cols <= col_cnt;
               col_cnt   <= '0;
            end else if (fv_fall) begin
               dv       <= 1'b1;
               active   <= 1'b0;
               num_rows <= row_cnt;
               num_cols <= last_cols;
            end
         end
      end
   end

   // Word payload, only looked at with dv
   always_ff @(posedge clk) begin
      if (fv_rise) begin
         tag  <= TAG_FRAME_START;
         data <= '0;
      end else if (lv) begin
         tag  <= TAG_PIXEL;
         data <= {{(DATA_W-PIXEL_W){1'b0}}, pix_data};
      end else if (lv_fall) begin
         tag  <= TAG_ROW_END;
         data <= DATA_W'(col_cnt);
      end else begin
         tag  <= TAG_FRAME_END;
         data <= DATA_W'(row_cnt);
      end
   end

   // Sensor must keep line valid inside frame valid
   a_lv_in_fv: assert property (@(posedge clk) disable iff (!resetb) lv |-> fv)
      else $error("frame_rx: lv high while fv low");

endmodule

`default_nettype wire

// ==== design/imager_pkg.sv ====
`default_nettype none

package imager_pkg;

   // ----------------------------------------------------------------------
   // Widths
   // ----------------------------------------------------------------------
   localparam int PIXEL_W    = 10;   // Sensor pixel
   localparam int DATA_W     = 16;   // Stream word payload
   localparam int DIM_W      = 16;   // Row and column counters
   localparam int REG_ADDR_W = 4;
   localparam int REG_DATA_W = 32;
   localparam int CAP_DEPTH  = 64;   // Default capture FIFO depth

   // Stream word kinds
   typedef enum logic [1:0] {
      TAG_FRAME_START = 2'd0,   // Data zero
      TAG_PIXEL       = 2'd1,   // Data is the pixel, zero-extended
      TAG_ROW_END     = 2'd2,   // Data is the column count
      TAG_FRAME_END   = 2'd3    // Data is the row count
   } stream_tag_t;

   // ----------------------------------------------------------------------
   // Register map
   // ----------------------------------------------------------------------
   localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 4'd0;
   localparam logic [REG_ADDR_W-1:0] REG_ARM     = 4'd1;
   localparam logic [REG_ADDR_W-1:0] REG_LUT     = 4'd2;
   localparam logic [REG_ADDR_W-1:0] REG_DIMS    = 4'd3;
   localparam logic [REG_ADDR_W-1:0] REG_CAP_IN  = 4'd4;
   localparam logic [REG_ADDR_W-1:0] REG_CAP_OUT = 4'd5;

   // REG_CTRL bits
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_MAP_ON_BIT = 1;

   // REG_LUT fields, table address above the value
   localparam int LUT_ADDR_LSB = 16;
   localparam int LUT_DATA_LSB = 0;

   // REG_DIMS fields
   localparam int DIMS_ROWS_LSB = 16;
   localparam int DIMS_COLS_LSB = 0;

   // ----------------------------------------------------------------------
   // Capture word layout
   // ----------------------------------------------------------------------
   localparam int CAP_VALID_BIT = 31;
   localparam int CAP_OVF_BIT   = 30;
   localparam int CAP_TAG_LSB   = 16;   // Two bits
   localparam int CAP_DATA_LSB  = 0;    // DATA_W bits

endpackage

`default_nettype wire
